// File: source/fetch_consts.svh
// Fetch subsystem constants: memory geometry, APB register map and stop word
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Instruction memory geometry, depth must stay 2**FETCH_AW
`define FETCH_IMEM_DEPTH 256                // 32-bit words
`define FETCH_AW         8                  // Word address bits

// APB byte offsets
`define FETCH_REG_CTRL   12'h000            // Bit 0 starts a run
`define FETCH_REG_STATUS 12'h004            // {halted, running}
`define FETCH_REG_COUNT  12'h008            // Delivered instructions
`define FETCH_REG_START  12'h00C            // Start word address
`define FETCH_IMEM_BASE  12'h400            // Word i at BASE + 4*i

// All-zero word ends the fetch
`define FETCH_STOP_WORD  32'h0000_0000

`endif

// File: source/fetch_pkg.sv
// Fetch package: controller states, predecode classes and shared bundles
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // Controller sequence
  typedef enum logic [1:0] {
    IDLE = 2'd0,                            // Waiting for start
    REQ  = 2'd1,                            // Memory read issued
    RESP = 2'd2,                            // Word valid, offered downstream
    HALT = 2'd3                             // Stop word delivered
  } fetch_state_e;

  // Predecode result
  typedef enum logic [1:0] {
    OP_SEQ  = 2'd0,                         // Falls through to pc+1
    OP_JAL  = 2'd1,                         // Redirect to jump target
    OP_STOP = 2'd2                          // Last word of the run
  } predec_op_e;

  // Output stream payload
  typedef struct packed {
    logic [31:0] pc;                        // Word address, zero-extended
    logic [31:0] instr;
  } fetch_out_t;

  // Memory write request from the host side
  typedef struct packed {
    logic                 en;
    logic [`FETCH_AW-1:0] addr;             // Word address
    logic [31:0]          data;
  } imem_wr_t;

  // Run control towards controller and PC
  typedef struct packed {
    logic                 start;            // One-cycle pulse
    logic [`FETCH_AW-1:0] start_pc;
  } fetch_ctrl_t;

  // Run status back to the register block
  typedef struct packed {
    logic        running;
    logic        halted;
    logic [15:0] count;                     // Saturating
  } fetch_stat_t;

endpackage

`default_nettype wire

// File: source/fetch_apb_regs.sv
// APB register block: run control, status, count, start PC and memory write window
`default_nettype none

`include "fetch_consts.svh"

module fetch_apb_regs (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire  [11:0]                paddr,
  input  wire  [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  wire  fetch_pkg::fetch_stat_t stat,
  output fetch_pkg::fetch_ctrl_t     ctrl,
  output fetch_pkg::imem_wr_t        imem_wr
);

  logic                 acc;                // Access phase
  logic                 wr_acc;
  logic                 rd_acc;
  logic                 hit_ctrl;
  logic                 hit_status;
  logic                 hit_count;
  logic                 hit_start;
  logic                 hit_win;
  logic                 mapped;
  logic                 busy;
  logic                 win_err;
  logic                 start_q;            // Start pulse register
  logic [`FETCH_AW-1:0] start_pc_q;         // START register

  assign acc    = psel & penable;
  assign wr_acc = acc & pwrite;
  assign rd_acc = acc & ~pwrite;

  // Address decode, exact offsets only
  assign hit_ctrl   = (paddr == `FETCH_REG_CTRL);
  assign hit_status = (paddr == `FETCH_REG_STATUS);
  assign hit_count  = (paddr == `FETCH_REG_COUNT);
  assign hit_start  = (paddr == `FETCH_REG_START);
  assign hit_win    = (paddr >= `FETCH_IMEM_BASE) &&
                      (paddr < (`FETCH_IMEM_BASE + 4 * `FETCH_IMEM_DEPTH)) &&
                      (paddr[1:0] == 2'b00);  // Word aligned window
  assign mapped     = hit_ctrl | hit_status | hit_count | hit_start | hit_win;

  // A pending start already counts as running
  assign busy    = stat.running | start_q;
  assign win_err = wr_acc & hit_win & busy; // Program is locked during a run

  assign pready  = 1'b1;                    // Zero wait states
  assign pslverr = acc & (~mapped | win_err);

  // Memory writes go straight through at the access edge
  assign imem_wr = '{
    en:   wr_acc & hit_win & ~busy,
    addr: paddr[`FETCH_AW+1:2],
    data: pwdata
  };

  assign ctrl = '{start: start_q, start_pc: start_pc_q};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q    <= 1'b0;
      start_pc_q <= '0;
    end else begin
      start_q <= wr_acc & hit_ctrl & pwdata[0] & ~busy; // Ignored mid-run
      if (wr_acc && hit_start) begin
        start_pc_q <= pwdata[`FETCH_AW-1:0];
      end
    end
  end

  // Read mux, window and CTRL read as zero
  always_comb begin
    prdata = 32'h0;
    if (rd_acc) begin
      if (hit_status) begin
        prdata = {30'h0, stat.halted, stat.running};
      end else if (hit_count) begin
        prdata = {16'h0, stat.count};
      end else if (hit_start) begin
        prdata = {{(32 - `FETCH_AW){1'b0}}, start_pc_q};
      end
    end
  end

endmodule

`default_nettype wire

// File: source/imem.sv
// Instruction memory: word array with one write port and a registered read port
`default_nettype none

`include "fetch_consts.svh"

module imem (
  input  wire                       clk,
  input  wire  fetch_pkg::imem_wr_t wr,
  input  wire                       rd_en,
  input  wire  [`FETCH_AW-1:0]      rd_addr,
  output logic [31:0]               rd_data
);

  logic [31:0] mem [`FETCH_IMEM_DEPTH];     // Loaded by the host

  // Host write port
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read register only moves on a request,
  // so the word stays put while the stream is stalled
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];              // One cycle latency
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_fsm.sv
// Fetch controller: sequences memory reads, holds under back-pressure, halts on stop
`default_nettype none

module fetch_fsm (
  input  wire                         clk,
  input  wire                         rst,
  input  wire  fetch_pkg::fetch_ctrl_t ctrl,
  input  wire  fetch_pkg::predec_op_e  op,
  input  wire                         out_ready,
  output logic                        rd_en,
  output logic                        advance,
  output logic                        out_valid,
  output logic                        running,
  output logic                        halted
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         xfer;                       // Stream handshake

  assign xfer = out_valid & out_ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ctrl.start) begin
          state_d = REQ;
        end
      end
      REQ: begin
        state_d = RESP;                     // Data lands next cycle
      end
      RESP: begin
        if (xfer) begin
          state_d = (op == OP_STOP) ? HALT : REQ;
        end
      end
      HALT: begin
        if (ctrl.start) begin
          state_d = REQ;                    // Restart clears halted
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs decoded from state
  assign rd_en     = (state_q == REQ);
  assign out_valid = (state_q == RESP);
  assign advance   = xfer;                  // PC moves on delivery
  assign running   = (state_q == REQ) | (state_q == RESP);
  assign halted    = (state_q == HALT);

endmodule

`default_nettype wire

// File: source/pc_counter.sv
// PC counter: current word address, sequential or jump next PC, delivered count
`default_nettype none

`include "fetch_consts.svh"

module pc_counter (
  input  wire                         clk,
  input  wire                         rst,
  input  wire  fetch_pkg::fetch_ctrl_t ctrl,
  input  wire                         advance,
  input  wire  fetch_pkg::predec_op_e  op,
  input  wire  [`FETCH_AW-1:0]        target,
  output logic [`FETCH_AW-1:0]        pc,
  output logic [15:0]                 count
);

  import fetch_pkg::*;

  logic [`FETCH_AW-1:0] pc_seq;             // pc+1
  logic [`FETCH_AW-1:0] pc_nxt;
  logic                 sel_jump;
  logic                 count_max;

  // Depth is a power of two, so the adder wraps for free
  assign pc_seq   = pc + 1'b1;
  assign sel_jump = (op == OP_JAL);
  assign pc_nxt   = sel_jump ? target : pc_seq;

  assign count_max = (count == 16'hFFFF);   // Saturate

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (ctrl.start) begin
      pc <= ctrl.start_pc;                  // Load for a new run
    end else if (advance) begin
      pc <= pc_nxt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= 16'h0;
    end else if (ctrl.start) begin
      count <= 16'h0;                       // New run, new count
    end else if (advance && !count_max) begin
      count <= count + 16'd1;
    end
  end

endmodule

`default_nettype wire

// File: source/jump_predecode.sv
// Jump predecoder: classifies the fetched word and forms the word-addressed JAL target
`default_nettype none

`include "fetch_consts.svh"

module jump_predecode (
  input  wire  [31:0]                instr,
  output fetch_pkg::predec_op_e      op,
  output logic [`FETCH_AW-1:0]       target,
  input  wire  [`FETCH_AW-1:0]       pc
);

  import fetch_pkg::*;

  localparam logic [6:0] JAL_OPCODE = 7'b1101111;

  logic signed [31:0] imm_j;                // Byte offset
  logic signed [31:0] imm_w;                // Word offset

  // imm[20|10:1|11|19:12] scattered over instr[31:12]
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_w = imm_j >>> 2;               // Keep the sign

  // Low bits only, wraps modulo the depth
  assign target = pc + imm_w[`FETCH_AW-1:0];

  always_comb begin
    if (instr == `FETCH_STOP_WORD) begin
      op = OP_STOP;
    end else if (instr[6:0] == JAL_OPCODE) begin
      op = OP_JAL;
    end else begin
      op = OP_SEQ;                          // Includes all other branches
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
// Fetch subsystem top: APB registers, memory, controller, PC counter and predecoder
`default_nettype none

`include "fetch_consts.svh"

module fetch_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire  [11:0]               paddr,
  input  wire  [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      out_valid,
  input  wire                       out_ready,
  output fetch_pkg::fetch_out_t     out_data
);

  import fetch_pkg::*;

  fetch_stat_t          stat;
  fetch_ctrl_t          ctrl;
  imem_wr_t             imem_wr;
  predec_op_e           op;
  logic                 rd_en;
  logic                 advance;
  logic                 running;
  logic                 halted;
  logic [31:0]          rd_data;            // Fetched word
  logic [`FETCH_AW-1:0] pc;
  logic [`FETCH_AW-1:0] target;
  logic [15:0]          count;

  assign stat     = '{running: running, halted: halted, count: count};
  assign out_data = '{pc: 32'(pc), instr: rd_data}; // Both frozen in RESP

  fetch_apb_regs u_regs (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .stat, .ctrl, .imem_wr
  );

  imem u_imem (
    .clk, .wr(imem_wr), .rd_en, .rd_addr(pc), .rd_data
  );

  fetch_fsm u_fsm (
    .clk, .rst, .ctrl, .op, .out_ready,
    .rd_en, .advance, .out_valid, .running, .halted
  );

  pc_counter u_pc (
    .clk, .rst, .ctrl, .advance, .op, .target, .pc, .count
  );

  jump_predecode u_predec (
    .instr(rd_data), .op, .target, .pc
  );

endmodule

`default_nettype wire

// File: sim/fetch_tb.sv
// Fetch subsystem testbench: APB program load, stream reference model and checks
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;

  localparam int          MAX_INSTR      = 200;             // Longest walk of the model
  localparam int          TIMEOUT_CYCLES = 3 * `FETCH_IMEM_DEPTH + 16 * MAX_INSTR + 32;
  localparam logic [31:0] RAND_SEED      = 32'h89bd_c4d5;
  localparam logic [31:0] OP_IMM         = 32'h0000_0013;   // addi class
  localparam logic [31:0] BRANCH_WORD    = 32'h0020_8463;   // beq x1, x2, +8

  logic        clk = 1'b0;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        out_valid;
  logic        out_ready;
  fetch_out_t  out_data;

  logic [31:0] prog [`FETCH_IMEM_DEPTH];                    // Shadow of the loaded memory
  fetch_out_t  exp_q [$];                                   // Predicted (pc, instr) pairs
  fetch_out_t  exp_head = '0;
  fetch_out_t  prev_data = '0;
  logic        stall_q = 1'b0;                              // Stalled in the last cycle
  int          exp_left = 0;
  int          run_len = 0;
  int          xfers = 0;
  int          errors = 0;
  int          cycles = 0;

  always #10 clk = ~clk;                                    // 20 ns period

  fetch_top dut (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .out_valid, .out_ready, .out_data
  );

  // Filler word, unique per address, never JAL or zero
  function automatic logic [31:0] fill_word(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {a, ~a, a ^ 8'h5a, 8'h13};
  endfunction

  // JAL x1 by a word offset
  function automatic logic [31:0] jal_word(input int words);
    logic [20:0] imm;
    imm = 21'(words * 4);                                   // Byte offset
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
  endfunction

  // J-immediate of a JAL divided by 4
  function automatic int jal_offset(input logic [31:0] instr);
    logic [20:0] imm;
    imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    return $signed({{11{imm[20]}}, imm}) / 4;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  // Walks the shadow program from start and queues every pair it should deliver
  task automatic build_expected(input int start);
    int          pc;
    logic [31:0] w;
    fetch_out_t  item;
    exp_q.delete();
    pc = start;
    for (int n = 0; n < MAX_INSTR; n++) begin
      w          = prog[pc];
      item.pc    = 32'(pc);
      item.instr = w;
      exp_q.push_back(item);
      if (w == `FETCH_STOP_WORD) begin
        break;
      end
      if (w[6:0] == 7'b1101111) begin
        pc = (pc + jal_offset(w)) & (`FETCH_IMEM_DEPTH - 1); // Wraps like the memory
      end else begin
        pc = (pc + 1) % `FETCH_IMEM_DEPTH;
      end
    end
    run_len  = exp_q.size();
    exp_left = run_len;
    exp_head = exp_q[0];
    xfers    = 0;
  endtask

  // One APB transfer, setup then access, inputs moved on falling edges
  task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;                                                     // Mid access cycle
    rdata   = prdata;
    err     = pslverr;
    expect_equal("pready", 32'h1, 32'(pready));             // No wait states
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, addr, data, rd, err);
    expect_equal("pslverr", 32'h0, 32'(err));
  endtask

  task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, 32'h0, data, err);
    expect_equal("pslverr", 32'h0, 32'(err));
  endtask

  task automatic start_run(input int start);
    build_expected(start);
    reg_write(`FETCH_REG_START, 32'(start));
    reg_write(`FETCH_REG_CTRL, 32'h1);
  endtask

  // Waits for the model to drain, then checks the halted state
  task automatic finish_run();
    logic [31:0] rd;
    wait (exp_left == 0);
    repeat (8) @(negedge clk);                              // Stream must stay quiet
    reg_read(`FETCH_REG_STATUS, rd);
    expect_equal("STATUS", 32'h2, rd);                      // Halted, not running
    reg_read(`FETCH_REG_COUNT, rd);
    expect_equal("COUNT", 32'(run_len), rd);
    expect_equal("transfers", 32'(run_len), 32'(xfers));
  endtask

  // Ready at about 70%
  always @(negedge clk) begin
    out_ready = ($urandom % 100) < 70;
  end

  // Stream monitor, pops the model on each handshake
  always @(posedge clk) begin
    stall_q   <= out_valid & ~out_ready;
    prev_data <= out_data;
    if (!rst && out_valid && out_ready) begin
      xfers++;
      if (exp_left > 0) begin
        void'(exp_q.pop_front());
        exp_left--;
        exp_head = (exp_left > 0) ? exp_q[0] : '0;
      end
    end
  end

  a_pair: assert property (@(posedge clk) disable iff (rst)
      (out_valid && out_ready) |-> (out_data == exp_head))
    else begin
      errors++;
      $display("ERROR t=%0t out_data expected=%h actual=%h", $time,
               $sampled(exp_head), $sampled(out_data));
    end

  // Nothing offered past the stop word or beyond the model
  a_none: assert property (@(posedge clk) disable iff (rst) out_valid |-> (exp_left > 0))
    else begin
      errors++;
      $display("Unexpected out_valid at t=%0t with no instruction predicted", $time);
    end

  a_hold: assert property (@(posedge clk) disable iff (rst) stall_q |-> (out_data == prev_data))
    else begin
      errors++;
      $display("ERROR t=%0t out_data expected=%h actual=%h", $time,
               $sampled(prev_data), $sampled(out_data));
    end

  // Hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d predicted transfers pending",
               cycles, exp_left);
      $display("Summary: %0d errors over %0d cycles", errors, cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    int          p2 [4];
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 12'h0;
    pwdata    = 32'h0;
    out_ready = 1'b0;
    p2        = '{254, 255, 0, 3};
    void'($urandom(RAND_SEED));
    repeat (4) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < `FETCH_IMEM_DEPTH; i++) begin
      prog[i] = fill_word(i);
    end
    for (int i = 8; i < 48; i++) begin
      prog[i] = ($urandom & 32'hFFFF_FF80) | OP_IMM;        // Straight-line code
    end
    prog[48] = jal_word(5);                                 // Forward to 53
    prog[54] = jal_word(-3);                                // Back to 51
    prog[52] = jal_word(6);                                 // Out to 58
    prog[59] = BRANCH_WORD;                                 // Falls through
    prog[60] = `FETCH_STOP_WORD;
    for (int i = 0; i < `FETCH_IMEM_DEPTH; i++) begin
      reg_write(12'(`FETCH_IMEM_BASE + 4 * i), prog[i]);
    end

    // Jumps and halt, with a locked window and an unmapped read mid-run
    start_run(8);
    apb_transfer(1'b1, 12'(`FETCH_IMEM_BASE + 4 * 60), 32'hdead_beef, rd, err);
    expect_equal("pslverr", 32'h1, 32'(err));
    apb_transfer(1'b0, 12'h010, 32'h0, rd, err);
    expect_equal("pslverr", 32'h1, 32'(err));
    expect_equal("prdata", 32'h0, rd);
    reg_read(`FETCH_REG_STATUS, rd);
    expect_equal("STATUS", 32'h1, rd);                      // Still running
    finish_run();

    // Restart at 254, wraps to 0, then jumps to the stop at 3
    prog[254] = ($urandom & 32'hFFFF_FF80) | OP_IMM;
    prog[255] = ($urandom & 32'hFFFF_FF80) | OP_IMM;
    prog[0]   = jal_word(3);
    prog[3]   = `FETCH_STOP_WORD;
    foreach (p2[k]) begin
      reg_write(12'(`FETCH_IMEM_BASE + 4 * p2[k]), prog[p2[k]]);
    end
    start_run(254);
    finish_run();

    // Second pass of the first program, stop word must be intact
    start_run(8);
    finish_run();

    $display("Summary: %0d errors over %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/fetch_pkg.sv
source/fetch_apb_regs.sv
source/imem.sv
source/fetch_fsm.sv
source/pc_counter.sv
source/jump_predecode.sv
source/fetch_top.sv
sim/fetch_tb.sv

// File: Makefile
TOP := fetch_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
